//--- design/bg_pkg.sv
/*
 * Background renderer shared definitions
 * bus widths, register map, control word layout, stride and tile-size
 * codes, and the fetch FSM states
 */
package bg_pkg;

	typedef logic [15:0] word_t;      // bus word, register and memory address
	typedef logic [16:0] byte_addr_t; // byte address into the tile map
	typedef logic [9:0]  pix_x_t;
	typedef logic [7:0]  line_addr_t; // four pixels per word
	typedef logic [7:0]  tile_t;
	typedef logic [3:0]  nibble_t;
	typedef logic [7:0]  color_t;
	typedef logic [3:0]  pal_t;
	typedef logic [3:0]  reg_addr_t;
	typedef logic [1:0]  stride_t;

	// register map
	localparam reg_addr_t REG_CTRL     = 4'd0;
	localparam reg_addr_t REG_SCROLL_X = 4'd1;
	localparam reg_addr_t REG_SCROLL_Y = 4'd2;
	localparam reg_addr_t REG_MAP_BASE = 4'd3;
	localparam reg_addr_t REG_SET_BASE = 4'd4;

	// control word fields
	localparam int CTRL_EN_BIT     = 0;
	localparam int CTRL_PAL_LSB    = 4;  // 4 bits
	localparam int CTRL_STRIDE_LSB = 8;  // 2 bits
	localparam int CTRL_SIZE_BIT   = 15;

	localparam logic TILE_SIZE_8X8 = 1'b1; // 0 selects 16x16

	// map stride in tiles
	localparam stride_t STRIDE_256 = 2'd0;
	localparam stride_t STRIDE_128 = 2'd1;
	localparam stride_t STRIDE_64  = 2'd2;
	localparam stride_t STRIDE_32  = 2'd3;

	localparam tile_t  TILE_TRANSPARENT = 8'hFF;
	localparam pix_x_t LINE_START       = 10'd16; // first rendered buffer pixel
	localparam pix_x_t PIX_PER_WORD     = 10'd4;

	typedef enum logic [2:0] {
		idle,
		prebegin,
		begin_line,
		fetch_map,
		wait_map,
		fetch_data,
		wait_data
	} fetch_state_t;

endpackage

//--- design/bg_cfg_if.sv
/*
 * Renderer internal buses
 * bg_cfg_if carries the layer configuration out of the register block,
 * line_wr_if carries render writes and the buffer swap pulse
 */
`timescale 1ns/1ps

interface bg_cfg_if;
	logic              enable;
	logic              tile_8x8;
	bg_pkg::stride_t   stride;
	bg_pkg::pal_t      pal_hi;
	bg_pkg::word_t     scroll_x;
	bg_pkg::word_t     scroll_y;
	bg_pkg::word_t     map_base; // word address
	bg_pkg::word_t     set_base; // word address

	modport regs (output enable, tile_8x8, stride, pal_hi, scroll_x, scroll_y,
		map_base, set_base);
	modport fetch (input enable, tile_8x8, stride, scroll_x, scroll_y, map_base, set_base);
	modport line (input pal_hi, scroll_x, tile_8x8);
endinterface

interface line_wr_if;
	logic               swap; // one cycle, on H_tick
	logic               wr;
	bg_pkg::line_addr_t wr_addr;
	bg_pkg::word_t      wr_data;

	modport src (output swap, wr, wr_addr, wr_data);
	modport dst (input swap, wr, wr_addr, wr_data);
endinterface

//--- design/bram_1r1w.sv
/*
 * Simple dual port RAM
 * one synchronous read port with a cycle of latency, one write port
 */
`timescale 1ns/1ps

module bram_1r1w #(
	parameter int WIDTH     = 16,
	parameter int ADDR_BITS = 8
) (
	input  logic                 CLK,
	input  logic [ADDR_BITS-1:0] rd_addr,
	output logic [WIDTH-1:0]     rd_data,
	input  logic [ADDR_BITS-1:0] wr_addr,
	input  logic [WIDTH-1:0]     wr_data,
	input  logic                 wr
);

	logic [WIDTH-1:0] mem [2**ADDR_BITS];

	// power-up contents are zero, an empty line
	initial begin
		for (int i = 0; i < 2**ADDR_BITS; i++)
			mem[i] = '0;
	end

	always_ff @(posedge CLK) begin
		if (wr)
			mem[wr_addr] <= wr_data;
		rd_data <= mem[rd_addr]; // old data on same-address write
	end

endmodule

//--- design/bg_regs.sv
/*
 * Background layer configuration registers
 * CPU write port decoded into control, scroll and base address fields
 */
`timescale 1ns/1ps

module bg_regs (
	input  logic              CLK,
	input  logic              RSTb,
	input  bg_pkg::reg_addr_t ADDRESS,
	input  bg_pkg::word_t     DATA_IN,
	input  logic              WR,
	bg_cfg_if.regs            cfg
);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			cfg.enable   <= 1'b0; // layer off
			cfg.tile_8x8 <= 1'b0;
			cfg.stride   <= '0;
			cfg.pal_hi   <= '0;
			cfg.scroll_x <= '0;
			cfg.scroll_y <= '0;
			cfg.map_base <= '0;
			cfg.set_base <= '0;
		end else if (WR) begin
			case (ADDRESS)
				bg_pkg::REG_CTRL: begin
					cfg.enable   <= DATA_IN[bg_pkg::CTRL_EN_BIT];
					cfg.pal_hi   <= DATA_IN[bg_pkg::CTRL_PAL_LSB +: 4];
					cfg.stride   <= DATA_IN[bg_pkg::CTRL_STRIDE_LSB +: 2];
					cfg.tile_8x8 <= DATA_IN[bg_pkg::CTRL_SIZE_BIT] == bg_pkg::TILE_SIZE_8X8;
				end
				bg_pkg::REG_SCROLL_X: cfg.scroll_x <= DATA_IN;
				bg_pkg::REG_SCROLL_Y: cfg.scroll_y <= DATA_IN;
				bg_pkg::REG_MAP_BASE: cfg.map_base <= DATA_IN;
				bg_pkg::REG_SET_BASE: cfg.set_base <= DATA_IN;
				default: ; // 5..15 unused
			endcase
		end
	end

endmodule

//--- design/tile_fetch.sv
/*
 * Scanline tile fetch engine
 * walks the tile map for the coming line and copies each tile row
 * into the render line buffer, one memory request per word.
 * transparent tiles skip the data fetch
 */
`timescale 1ns/1ps

module tile_fetch #(
	parameter int LINE_WIDTH = 720
) (
	input  logic           CLK,
	input  logic           RSTb,
	input  logic           H_tick,
	input  bg_pkg::pix_x_t display_y,
	bg_cfg_if.fetch        cfg,
	line_wr_if.src         wr,
	output bg_pkg::word_t  memory_address,
	input  bg_pkg::word_t  memory_data,
	output logic           rvalid,
	input  logic           rready
);

	bg_pkg::fetch_state_t state;
	bg_pkg::word_t        line_row;  // scroll_y + display_y
	bg_pkg::byte_addr_t   map_byte;
	bg_pkg::pix_x_t       render_x;
	bg_pkg::tile_t        tile;
	logic [1:0]           word_cnt;
	logic                 restart;
	logic                 last_word;
	bg_pkg::pix_x_t       tile_px;
	bg_pkg::word_t        row_tile;
	bg_pkg::word_t        col_tile;
	bg_pkg::byte_addr_t   row_off;
	bg_pkg::byte_addr_t   map_start;
	bg_pkg::word_t        data_start;

	assign restart   = H_tick && cfg.enable;
	assign tile_px   = cfg.tile_8x8 ? 10'd8 : 10'd16;
	assign row_tile  = cfg.tile_8x8 ? line_row >> 3 : line_row >> 4;
	assign col_tile  = cfg.tile_8x8 ? cfg.scroll_x >> 3 : cfg.scroll_x >> 4;
	assign last_word = word_cnt == (cfg.tile_8x8 ? 2'd1 : 2'd3);

	always_comb begin
		case (cfg.stride)
			bg_pkg::STRIDE_256: row_off = bg_pkg::byte_addr_t'(row_tile) << 8;
			bg_pkg::STRIDE_128: row_off = bg_pkg::byte_addr_t'(row_tile) << 7;
			bg_pkg::STRIDE_64:  row_off = bg_pkg::byte_addr_t'(row_tile) << 6;
			default:            row_off = bg_pkg::byte_addr_t'(row_tile) << 5;
		endcase
	end

	// map byte address of the first tile on the line, wraps at 17 bits
	assign map_start = {cfg.map_base, 1'b0} + row_off + bg_pkg::byte_addr_t'(col_tile);

	// tiles stored one after another, 4bpp
	assign data_start = cfg.tile_8x8
		? cfg.set_base + {4'd0, tile, 4'd0} + {12'd0, line_row[2:0], 1'b0}
		: cfg.set_base + {2'd0, tile, 6'd0} + {10'd0, line_row[3:0], 2'b00};

	assign rvalid     = state == bg_pkg::wait_map || state == bg_pkg::wait_data;
	assign wr.swap    = restart;
	assign wr.wr      = state == bg_pkg::wait_data && rready && !restart;
	assign wr.wr_addr = render_x[9:2];
	assign wr.wr_data = memory_data;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state          <= bg_pkg::idle;
			word_cnt       <= '0;
			memory_address <= '0;
		end else if (restart) begin
			state    <= bg_pkg::prebegin; // abandons any fetch in flight
			word_cnt <= '0;
		end else begin
			case (state)
				bg_pkg::idle: ;
				bg_pkg::prebegin: begin
					line_row <= cfg.scroll_y + bg_pkg::word_t'(display_y);
					state    <= bg_pkg::begin_line;
				end
				bg_pkg::begin_line: begin
					map_byte <= map_start;
					render_x <= bg_pkg::LINE_START;
					state    <= bg_pkg::fetch_map;
				end
				bg_pkg::fetch_map: begin
					if (render_x == bg_pkg::pix_x_t'(LINE_WIDTH)) begin
						state <= bg_pkg::idle; // line done
					end else begin
						memory_address <= map_byte[16:1];
						state          <= bg_pkg::wait_map;
					end
				end
				bg_pkg::wait_map: begin
					if (rready) begin
						tile  <= map_byte[0] ? memory_data[15:8] : memory_data[7:0];
						state <= bg_pkg::fetch_data;
					end
				end
				bg_pkg::fetch_data: begin
					if (tile == bg_pkg::TILE_TRANSPARENT) begin
						render_x <= render_x + tile_px;
						map_byte <= map_byte + 17'd1;
						state    <= bg_pkg::fetch_map;
					end else begin
						memory_address <= data_start;
						word_cnt       <= '0;
						state          <= bg_pkg::wait_data;
					end
				end
				bg_pkg::wait_data: begin
					if (rready) begin
						render_x       <= render_x + bg_pkg::PIX_PER_WORD;
						memory_address <= memory_address + 16'd1;
						word_cnt       <= word_cnt + 2'd1;
						if (last_word) begin
							map_byte <= map_byte + 17'd1;
							state    <= bg_pkg::fetch_map;
						end
					end
				end
				default: state <= bg_pkg::idle;
			endcase
		end
	end

	// request held until the memory answers
	a_addr_stable: assert property (@(posedge CLK) disable iff (!RSTb)
		rvalid && !rready |=> $stable(memory_address));

	// writes stay inside the line and never come from idle
	a_no_wr_idle: assert property (@(posedge CLK) disable iff (!RSTb)
		wr.wr |-> state != bg_pkg::idle && render_x < bg_pkg::pix_x_t'(LINE_WIDTH));

endmodule

//--- design/line_buffer.sv
/*
 * Ping-pong scanline buffers
 * fetch side writes the render buffer, display side reads the other one
 * with fine scroll applied and clears each word behind the beam
 */
`timescale 1ns/1ps

module line_buffer (
	input  logic           CLK,
	input  logic           RSTb,
	input  bg_pkg::pix_x_t display_x,
	bg_cfg_if.line         cfg,
	line_wr_if.dst         wr,
	output bg_pkg::color_t color_index
);

	logic               render_sel;
	logic               rd_sel;    // display buffer at read time
	logic [1:0]         nib_sel;
	bg_pkg::pix_x_t     rd_pos;
	bg_pkg::line_addr_t rd_addr;
	bg_pkg::line_addr_t clr_addr;
	bg_pkg::line_addr_t buf_wr_addr [2];
	bg_pkg::word_t      buf_wr_data [2];
	bg_pkg::word_t      buf_rd_data [2];
	logic               buf_wr [2];
	bg_pkg::word_t      rd_word;
	bg_pkg::nibble_t    pixel;

	// fine scroll is scroll_x mod tile size
	assign rd_pos = display_x + (cfg.tile_8x8 ? {7'd0, cfg.scroll_x[2:0]}
	                                          : {6'd0, cfg.scroll_x[3:0]});
	assign rd_addr  = rd_pos[9:2];
	assign clr_addr = display_x[9:2] - 8'd1; // word already shown

	for (genvar g = 0; g < 2; g++) begin : g_buf
		logic is_render;

		assign is_render      = render_sel == 1'(g);
		assign buf_wr[g]      = is_render ? wr.wr : 1'b1;
		assign buf_wr_addr[g] = is_render ? wr.wr_addr : clr_addr;
		assign buf_wr_data[g] = is_render ? wr.wr_data : '0;

		bram_1r1w #(
			.WIDTH($bits(bg_pkg::word_t)),
			.ADDR_BITS($bits(bg_pkg::line_addr_t))
		) u_ram (
			.CLK(CLK),
			.rd_addr(rd_addr),
			.rd_data(buf_rd_data[g]),
			.wr_addr(buf_wr_addr[g]),
			.wr_data(buf_wr_data[g]),
			.wr(buf_wr[g])
		);
	end

	assign rd_word = buf_rd_data[rd_sel];
	assign pixel   = rd_word[{nib_sel, 2'b00} +: 4]; // low nibble is leftmost

	always_ff @(posedge CLK) begin
		rd_sel  <= !render_sel;
		nib_sel <= rd_pos[1:0];
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			render_sel  <= 1'b0;
			color_index <= '0;
		end else begin
			if (wr.swap)
				render_sel <= !render_sel;
			color_index <= {cfg.pal_hi, pixel};
		end
	end

	// a write alongside the swap would land in the buffer being shown next
	a_wr_not_display: assert property (@(posedge CLK) disable iff (!RSTb)
		wr.wr |-> !wr.swap);

endmodule

//--- design/bg_renderer.sv
/*
 * Tile background renderer
 * single layer, 16x16 or 8x8 tiles of 4bpp pixels, fetched per scanline
 * over a request/ready memory port into ping-pong line buffers
 */
`timescale 1ns/1ps

module bg_renderer #(
	parameter int LINE_WIDTH = 720 // multiple of 16, at most 1008
) (
	input  logic              CLK,
	input  logic              RSTb,
	input  bg_pkg::reg_addr_t ADDRESS,
	input  bg_pkg::word_t     DATA_IN,
	input  logic              WR,
	input  logic              H_tick,
	input  bg_pkg::pix_x_t    display_x,
	input  bg_pkg::pix_x_t    display_y,
	output bg_pkg::color_t    color_index,
	output bg_pkg::word_t     memory_address,
	input  bg_pkg::word_t     memory_data,
	output logic              rvalid,
	input  logic              rready
);

	bg_cfg_if  cfg_bus ();
	line_wr_if wr_bus ();

	bg_regs u_regs (
		.CLK(CLK),
		.RSTb(RSTb),
		.ADDRESS(ADDRESS),
		.DATA_IN(DATA_IN),
		.WR(WR),
		.cfg(cfg_bus.regs)
	);

	tile_fetch #(
		.LINE_WIDTH(LINE_WIDTH)
	) u_fetch (
		.CLK(CLK),
		.RSTb(RSTb),
		.H_tick(H_tick),
		.display_y(display_y),
		.cfg(cfg_bus.fetch),
		.wr(wr_bus.src),
		.memory_address(memory_address),
		.memory_data(memory_data),
		.rvalid(rvalid),
		.rready(rready)
	);

	line_buffer u_line (
		.CLK(CLK),
		.RSTb(RSTb),
		.display_x(display_x),
		.cfg(cfg_bus.line),
		.wr(wr_bus.dst),
		.color_index(color_index)
	);

endmodule

//--- test/tb_clock.sv
/*
 * Testbench clock and reset
 * free running clock, active low reset held for a number of cycles
 */
`timescale 1ns/1ps

module tb_clock #(
	parameter int HALF_PERIOD  = 50, // ns
	parameter int RESET_CYCLES = 8
) (
	output logic CLK,
	output logic RSTb
);

	initial begin
		CLK = 1'b0;
		forever #(HALF_PERIOD) CLK = ~CLK;
	end

	initial begin
		RSTb = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		RSTb <= 1'b1; // released on a rising edge
	end

endmodule

//--- test/tb_bg_renderer.sv
/*
 * Tile background renderer testbench
 * random configurations against a reference model of the map and tile
 * rules, with a random-latency memory model that logs every request
 */
`timescale 1ns/1ps

module tb_bg_renderer;

	localparam int LINE_WIDTH = 64;
	localparam int NUM_LINES  = 14; // rendered lines plus reset and disabled runs

	logic        CLK;
	logic        RSTb;
	logic [3:0]  ADDRESS;
	logic [15:0] DATA_IN;
	logic        WR;
	logic        H_tick;
	logic [9:0]  display_x;
	logic [9:0]  display_y;
	logic [7:0]  color_index;
	logic [15:0] memory_address;
	logic [15:0] memory_data = '0;
	logic        rvalid;
	logic        rready = 1'b0;

	logic [15:0] mem [4096];
	logic [15:0] req_log [$];
	int          seed = 25757;
	int          wait_cnt;
	int          checks;
	int          errors;
	int          test_checks;
	int          test_errors;

	// configuration of the line under test
	logic        c_8x8;
	logic [1:0]  c_stride;
	logic [3:0]  c_pal;
	logic [15:0] c_scroll_x;
	logic [15:0] c_scroll_y;
	logic [15:0] c_map_base;
	logic [15:0] c_set_base;
	logic [9:0]  c_display_y;

	tb_clock u_clock (.CLK(CLK), .RSTb(RSTb));

	bg_renderer #(
		.LINE_WIDTH(LINE_WIDTH)
	) uut (
		.CLK(CLK),
		.RSTb(RSTb),
		.ADDRESS(ADDRESS),
		.DATA_IN(DATA_IN),
		.WR(WR),
		.H_tick(H_tick),
		.display_x(display_x),
		.display_y(display_y),
		.color_index(color_index),
		.memory_address(memory_address),
		.memory_data(memory_data),
		.rvalid(rvalid),
		.rready(rready)
	);

	// memory answers each request after 0 to 3 idle cycles
	always @(posedge CLK) begin
		if (!RSTb) begin
			rready   <= 1'b0;
			wait_cnt <= 0;
		end else if (rready) begin
			rready   <= 1'b0;
			wait_cnt <= $random(seed) & 3;
		end else if (rvalid) begin
			if (wait_cnt == 0) begin
				rready      <= 1'b1;
				memory_data <= mem[memory_address[11:0]];
				req_log.push_back(memory_address);
			end else begin
				wait_cnt <= wait_cnt - 1;
			end
		end
	end

	initial begin
		#(NUM_LINES * 600 * 100);
		$display("timeout: the run did not finish within the time allowed");
		$display("TESTBENCH FAILED");
		$finish;
	end

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail time=%0t %s got=%h expected=%h", $time, name, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		$display("test %-14s %0d checks, %0d errors", name, checks - test_checks,
			errors - test_errors);
		test_checks = checks;
		test_errors = errors;
	endtask

	function automatic int tile_px();
		return c_8x8 ? 8 : 16;
	endfunction

	function automatic logic [15:0] line_row();
		return c_scroll_y + 16'(c_display_y);
	endfunction

	// byte address of tile k of the line, wraps at 17 bits
	function automatic logic [16:0] map_byte_at(input int k);
		int sum;
		sum = 2 * c_map_base + (line_row() / tile_px()) * (256 >> c_stride)
			+ c_scroll_x / tile_px() + k;
		return 17'(sum);
	endfunction

	function automatic logic [7:0] tile_at(input int k);
		logic [16:0] mb;
		logic [15:0] w;
		mb = map_byte_at(k);
		w  = mem[mb[12:1]];
		return mb[0] ? w[15:8] : w[7:0];
	endfunction

	// first data word of the current row of a tile
	function automatic logic [15:0] tile_row_addr(input logic [7:0] tile);
		if (c_8x8)
			return c_set_base + 16'(tile) * 16'd16 + 16'(line_row() % 8) * 16'd2;
		return c_set_base + 16'(tile) * 16'd64 + 16'(line_row() % 16) * 16'd4;
	endfunction

	function automatic logic [7:0] expect_pixel(input int d);
		int          b;
		int          p;
		logic [7:0]  tile;
		logic [15:0] w;
		b = d + c_scroll_x % tile_px();
		if (b < 16 || b >= LINE_WIDTH)
			return {c_pal, 4'h0};
		p    = (b - 16) % tile_px();
		tile = tile_at((b - 16) / tile_px());
		if (tile == 8'hFF)
			return {c_pal, 4'h0};
		w = mem[12'(tile_row_addr(tile) + 16'(p / 4))];
		return {c_pal, w[(p % 4) * 4 +: 4]};
	endfunction

	task automatic set_transparent(input int k);
		logic [16:0] mb;
		mb = map_byte_at(k);
		if (mb[0])
			mem[mb[12:1]][15:8] = 8'hFF;
		else
			mem[mb[12:1]][7:0] = 8'hFF;
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [15:0] data);
		@(posedge CLK);
		ADDRESS <= addr;
		DATA_IN <= data;
		WR      <= 1'b1;
		@(posedge CLK);
		WR <= 1'b0;
	endtask

	task automatic pulse_tick();
		@(posedge CLK);
		H_tick <= 1'b1;
		@(posedge CLK);
		H_tick <= 1'b0;
	endtask

	// map word per tile, then its data words unless transparent
	task automatic check_requests();
		logic [15:0] exp_q [$];
		logic [7:0]  tile;
		int          n;
		for (int k = 0; k < (LINE_WIDTH - 16) / tile_px(); k++) begin
			exp_q.push_back(map_byte_at(k) >> 1);
			tile = tile_at(k);
			if (tile != 8'hFF) begin
				for (int w = 0; w < tile_px() / 4; w++)
					exp_q.push_back(tile_row_addr(tile) + 16'(w));
			end
		end
		compare_value("request count", req_log.size(), exp_q.size());
		n = req_log.size() < exp_q.size() ? req_log.size() : exp_q.size();
		for (int i = 0; i < n; i++)
			compare_value("memory_address", req_log[i], exp_q[i]);
	endtask

	// beam runs a few pixels past the line so the last word is cleared too
	task automatic sweep_line();
		logic [7:0] exp_q [$];
		for (int i = 0; i < LINE_WIDTH + 3; i++) begin
			@(posedge CLK);
			if (i >= 3)
				compare_value("color_index", color_index, exp_q.pop_front());
			display_x <= 10'(i);
			if (i < LINE_WIDTH)
				exp_q.push_back(expect_pixel(i));
		end
		@(posedge CLK);
		display_x <= '0; // beam back to the left edge until the next line
	endtask

	// mode 0 plain map, 1 some tiles transparent, 2 all transparent and palette 0
	task automatic run_line(input logic is_8x8, input logic [1:0] stride, input int mode);
		c_8x8       = is_8x8;
		c_stride    = stride;
		c_pal       = (mode == 2) ? 4'h0 : 4'($random(seed));
		c_scroll_x  = 16'($random(seed));
		c_scroll_y  = 16'($random(seed));
		c_map_base  = 16'($random(seed));
		c_set_base  = 16'($random(seed));
		c_display_y = 10'($random(seed));
		for (int k = 0; k < (LINE_WIDTH - 16) / tile_px(); k++) begin
			if (mode == 2 || (mode == 1 && (k == 1 || ($random(seed) & 1))))
				set_transparent(k);
		end
		write_reg(bg_pkg::REG_SCROLL_X, c_scroll_x);
		write_reg(bg_pkg::REG_SCROLL_Y, c_scroll_y);
		write_reg(bg_pkg::REG_MAP_BASE, c_map_base);
		write_reg(bg_pkg::REG_SET_BASE, c_set_base);
		write_reg(bg_pkg::REG_CTRL, {c_8x8, 5'd0, c_stride, c_pal, 3'd0, 1'b1});
		@(posedge CLK);
		display_y <= c_display_y;
		pulse_tick();
		@(posedge CLK);
		req_log.delete(); // drop anything left from the previous fetch
		repeat (400) @(posedge CLK);
		check_requests();
		pulse_tick();
		sweep_line();
	endtask

	// rvalid stays low for 8 cycles only once the fetch FSM is idle
	task automatic wait_fetch_idle();
		int quiet;
		quiet = 0;
		while (quiet < 8) begin
			@(posedge CLK);
			quiet = rvalid ? 0 : quiet + 1;
		end
	endtask

	initial begin
		ADDRESS   = '0;
		DATA_IN   = '0;
		WR        = 1'b0;
		H_tick    = 1'b0;
		display_x = '0;
		display_y = '0;
		checks    = 0;
		errors    = 0;
		for (int i = 0; i < 4096; i++)
			mem[i] = 16'($random(seed));
		test_checks = 0;
		test_errors = 0;

		repeat (3) @(posedge CLK);
		while (!RSTb) begin
			@(posedge CLK);
			compare_value("rvalid", rvalid, 1'b0);
			compare_value("color_index", color_index, 8'h00);
		end
		repeat (10) begin
			@(posedge CLK);
			compare_value("rvalid", rvalid, 1'b0);
			compare_value("color_index", color_index, 8'h00);
		end
		end_test("reset");

		for (int i = 0; i < 4; i++)
			run_line(1'b0, 2'($random(seed)), 0);
		end_test("tile_16x16");

		for (int i = 0; i < 4; i++)
			run_line(1'b1, 2'(i), 0);
		end_test("tile_8x8");

		run_line(1'b0, 2'($random(seed)), 1);
		run_line(1'b1, 2'($random(seed)), 1);
		end_test("transparent");

		wait_fetch_idle();
		write_reg(bg_pkg::REG_CTRL, 16'h0120); // fields set, enable clear
		pulse_tick();
		repeat (400) begin
			@(posedge CLK);
			compare_value("rvalid", rvalid, 1'b0);
		end
		end_test("disabled");

		run_line(1'b0, 2'($random(seed)), 0);
		run_line(1'b1, 2'($random(seed)), 2);
		end_test("clear_on_read");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- bg_renderer.f
design/bg_pkg.sv
design/bg_cfg_if.sv
design/bram_1r1w.sv
design/bg_regs.sv
design/tile_fetch.sv
design/line_buffer.sv
design/bg_renderer.sv
test/tb_clock.sv
test/tb_bg_renderer.sv

//--- Bender.yml
package:
  name: bg_renderer

sources:
  - design/bg_pkg.sv
  - design/bg_cfg_if.sv
  - design/bram_1r1w.sv
  - design/bg_regs.sv
  - design/tile_fetch.sv
  - design/line_buffer.sv
  - design/bg_renderer.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/tb_bg_renderer.sv
